// File: filelist.f
source/pmem_axi_pkg.sv
source/pmem_ram_pkg.sv
source/pmem_fifo.sv
source/pmem_req_builder.sv
source/pmem_resp_unpack.sv
source/ddr3_axi_pmem.sv
sim/pmem_assertions.sv
sim/tb_ddr3_axi_pmem.sv

// File: Makefile
# Verilator build and run for the AXI pipelined memory slave

VERILATOR ?= verilator
TOP       ?= tb_ddr3_axi_pmem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_ddr3_axi_pmem.sv
// Testbench for the AXI4 pipelined memory slave
// Clock, reset, line memory model with random stalls, shadow memory,
// R/B monitors, directed tests, timeout and final summary

`timescale 1ns/100ps

module tb_ddr3_axi_pmem
  import pmem_axi_pkg::*, pmem_ram_pkg::*;
();

  // Five tests of well under 1000 cycles each
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MEM_LINES      = 256;
  localparam int READ_LIMIT     = 6;

  logic       clk_i;
  logic       rst_i;
  logic       axi_awvalid_i, axi_wvalid_i, axi_wlast_i, axi_bready_i;
  logic       axi_arvalid_i, axi_rready_i;
  axi_addr_t  axi_awaddr_i, axi_araddr_i;
  axi_id_t    axi_awid_i, axi_arid_i;
  axi_len_t   axi_awlen_i, axi_arlen_i;
  logic [1:0] axi_awburst_i, axi_arburst_i;
  axi_data_t  axi_wdata_i;
  axi_strb_t  axi_wstrb_i;
  logic       ram_accept_i, ram_ack_i;
  req_tag_t   ram_resp_id_i;
  ram_data_t  ram_read_data_i;
  logic       axi_awready_o, axi_wready_o, axi_bvalid_o, axi_arready_o;
  logic       axi_rvalid_o, axi_rlast_o, ram_rd_o;
  axi_resp_t  axi_bresp_o, axi_rresp_o;
  axi_id_t    axi_bid_o, axi_rid_o;
  axi_data_t  axi_rdata_o;
  ram_mask_t  ram_wr_o;
  ram_addr_t  ram_addr_o;
  ram_data_t  ram_write_data_o;
  req_tag_t   ram_req_id_o;

  ram_data_t   mem [MEM_LINES];
  logic [7:0]  shadow [MEM_LINES * LINE_BYTES];
  logic        pipe_v [4];
  req_tag_t    pipe_tag [4];
  ram_data_t   pipe_data [4];
  logic [36:0] exp_r [$];
  axi_id_t     exp_b [$];
  logic [31:0] stall_lfsr;
  logic [31:0] data_lfsr;
  int          resp_level;
  int          rd_out;
  int          cycles;
  int          errors;
  int          checks;
  int          tests;

  ddr3_axi_pmem ddr3_axi_pmem_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v  = {v[30:0], st[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0] ^ 16'hc3a5, a[15:0] + 16'h1357};
  endfunction

  function automatic axi_data_t shadow_word(input int a);
    return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  //------------------------------------------------------------
  // Memory model with a 3 cycle response delay
  //------------------------------------------------------------
  always @(negedge clk_i) begin : memory_model
    int   pend;
    int   line;
    logic ok;
    if (rst_i) begin
      ram_accept_i = 1'b0;
      ram_ack_i    = 1'b0;
      for (int s = 0; s < 4; s++) begin
        pipe_v[s] = 1'b0;
      end
    end else begin
      for (int s = 3; s > 0; s--) begin
        pipe_v[s]    = pipe_v[s - 1];
        pipe_tag[s]  = pipe_tag[s - 1];
        pipe_data[s] = pipe_data[s - 1];
      end
      pipe_v[0]       = 1'b0;
      ram_ack_i       = pipe_v[3];
      ram_resp_id_i   = pipe_tag[3];
      ram_read_data_i = pipe_data[3];
      pend = 0;
      for (int s = 1; s < 4; s++) begin
        pend += int'(pipe_v[s]);
      end
      // Response FIFO room is tracked here as its accept is not wired back
      ok = (take_bits(stall_lfsr, 2) != 32'd0) && (resp_level + pend < RESP_FIFO_DEPTH);
      ram_accept_i = ok;
      if (ok && (ram_rd_o || (ram_wr_o != '0))) begin
        line = int'(ram_addr_o[11:4]);
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (ram_wr_o[b]) begin
            mem[line][b*8 +: 8] = ram_write_data_o[b*8 +: 8];
          end
        end
        if (ram_rd_o || ram_req_id_o[TAG_LAST_BIT]) begin
          pipe_v[0]    = 1'b1;
          pipe_tag[0]  = ram_req_id_o;
          pipe_data[0] = mem[line];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      resp_level <= 0;
    end else begin
      resp_level <= resp_level + int'(ram_ack_i) - int'(ddr3_axi_pmem_i.resp_pop);
    end
  end

  //------------------------------------------------------------
  // Monitors and timeout
  //------------------------------------------------------------
  always @(posedge clk_i) begin : r_monitor
    logic [36:0] e;
    if (!rst_i && axi_rvalid_o && axi_rready_i) begin
      if (exp_r.size() == 0) begin
        errors++;
        $display("Unexpected R beat with id %h", axi_rid_o);
      end else begin
        e = exp_r.pop_front();
        check_eq("rid", 32'(axi_rid_o), 32'(e[36:33]));
        check_eq("rlast", 32'(axi_rlast_o), 32'(e[32]));
        check_eq("rdata", axi_rdata_o, e[31:0]);
      end
    end
  end

  always @(posedge clk_i) begin : b_monitor
    if (!rst_i && axi_bvalid_o && axi_bready_i) begin
      if (exp_b.size() == 0) begin
        errors++;
        $display("Unexpected B response with id %h", axi_bid_o);
      end else begin
        check_eq("bid", 32'(axi_bid_o), 32'(exp_b.pop_front()));
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      rd_out <= 0;
    end else begin
      rd_out <= rd_out + int'(axi_arvalid_i && axi_arready_o)
                - int'(axi_rvalid_o && axi_rready_i && axi_rlast_o);
      if (rd_out > READ_LIMIT) begin
        errors++;
        $display("More than %0d read bursts are outstanding", READ_LIMIT);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //------------------------------------------------------------
  // AXI drivers
  //------------------------------------------------------------
  task automatic send_write(input axi_addr_t addr, input axi_id_t id, input int beats,
                            input logic partial);
    axi_data_t data [$];
    axi_strb_t strb [$];
    axi_data_t d;
    axi_strb_t s;
    int        a;
    for (int i = 0; i < beats; i++) begin
      d = take_bits(data_lfsr, 32);
      s = partial ? axi_strb_t'(take_bits(data_lfsr, 4)) : 4'hf;
      // An all-zero last line would never be answered
      if (s == '0) begin
        s = 4'h1;
      end
      a = int'(addr[11:0]) + 4 * i;
      for (int b = 0; b < 4; b++) begin
        if (s[b]) begin
          shadow[a + b] = d[b*8 +: 8];
        end
      end
      data.push_back(d);
      strb.push_back(s);
    end
    exp_b.push_back(id);
    @(negedge clk_i);
    axi_awvalid_i = 1'b1;
    axi_awaddr_i  = addr;
    axi_awid_i    = id;
    axi_awlen_i   = axi_len_t'(beats - 1);
    axi_awburst_i = BURST_INCR;
    do @(posedge clk_i); while (!axi_awready_o);
    @(negedge clk_i);
    axi_awvalid_i = 1'b0;
    for (int i = 0; i < beats; i++) begin
      axi_wvalid_i = 1'b1;
      axi_wdata_i  = data[i];
      axi_wstrb_i  = strb[i];
      axi_wlast_i  = (i == beats - 1);
      do @(posedge clk_i); while (!axi_wready_o);
      @(negedge clk_i);
    end
    axi_wvalid_i = 1'b0;
    axi_wlast_i  = 1'b0;
  endtask

  task automatic issue_read(input axi_addr_t addr, input axi_id_t id, input int beats);
    int a;
    for (int i = 0; i < beats; i++) begin
      a = int'(addr[11:0]) + 4 * i;
      exp_r.push_back({id, (i == beats - 1), shadow_word(a)});
    end
    @(negedge clk_i);
    axi_arvalid_i = 1'b1;
    axi_araddr_i  = addr;
    axi_arid_i    = id;
    axi_arlen_i   = axi_len_t'(beats - 1);
    axi_arburst_i = BURST_INCR;
    do @(posedge clk_i); while (!axi_arready_o);
    @(negedge clk_i);
    axi_arvalid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_r.size() != 0 || exp_b.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests++;
    $display("%s finished, %0d errors", name, errors - start_errors);
  endtask

  //------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------
  task automatic test_single();
    int e0;
    e0 = errors;
    send_write(32'h104, 4'd3, 1, 1'b0);
    wait_idle();
    issue_read(32'h104, 4'd5, 1);
    wait_idle();
    end_test("test_single", e0);
  endtask

  task automatic test_burst();
    int e0;
    e0 = errors;
    send_write(32'h200, 4'd1, 4, 1'b0);
    send_write(32'h300, 4'd2, 16, 1'b0);
    wait_idle();
    issue_read(32'h200, 4'd4, 4);
    issue_read(32'h300, 4'd6, 16);
    wait_idle();
    end_test("test_burst", e0);
  endtask

  task automatic test_strobe();
    int e0;
    e0 = errors;
    send_write(32'h140, 4'd7, 4, 1'b1);
    send_write(32'h108, 4'd7, 1, 1'b1);
    wait_idle();
    issue_read(32'h140, 4'd2, 4);
    issue_read(32'h108, 4'd2, 1);
    wait_idle();
    end_test("test_strobe", e0);
  endtask

  task automatic test_interleave();
    int e0;
    e0 = errors;
    fork
      begin
        send_write(32'h500, 4'd8, 8, 1'b0);
        send_write(32'h580, 4'd11, 4, 1'b1);
      end
      begin
        issue_read(32'h300, 4'd9, 16);
        issue_read(32'h200, 4'd10, 4);
      end
    join
    wait_idle();
    issue_read(32'h500, 4'd12, 8);
    issue_read(32'h580, 4'd13, 4);
    wait_idle();
    end_test("test_interleave", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    @(negedge clk_i);
    axi_rready_i = 1'b0;
    axi_bready_i = 1'b0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          issue_read(32'h400 + 32'(16 * i), axi_id_t'(i), 4);
        end
      end
      begin
        send_write(32'h700, 4'd12, 4, 1'b0);
        send_write(32'h740, 4'd13, 1, 1'b0);
      end
      begin
        repeat (20) @(negedge clk_i);
        axi_rready_i = 1'b1;
        axi_bready_i = 1'b1;
      end
    join
    wait_idle();
    check_eq("open read bursts", 32'(rd_out), 32'd0);
    end_test("test_backpressure", e0);
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial begin
    axi_data_t word;
    rst_i = 1'b1;
    {axi_awvalid_i, axi_wvalid_i, axi_wlast_i, axi_arvalid_i} = '0;
    {axi_awaddr_i, axi_araddr_i, axi_wdata_i} = '0;
    {axi_awid_i, axi_arid_i, axi_awlen_i, axi_arlen_i, axi_wstrb_i} = '0;
    axi_awburst_i = BURST_INCR;
    axi_arburst_i = BURST_INCR;
    axi_rready_i  = 1'b1;
    axi_bready_i  = 1'b1;
    {ram_accept_i, ram_ack_i, ram_resp_id_i, ram_read_data_i} = '0;
    stall_lfsr = 32'h6fe2;
    data_lfsr  = 32'h6fe2;
    {cycles, errors, checks, tests} = '0;
    for (int a = 0; a < MEM_LINES * LINE_BYTES; a += 4) begin
      word = fill_word(32'(a));
      mem[a / LINE_BYTES][(a % LINE_BYTES)*8 +: 32] = word;
      for (int b = 0; b < 4; b++) begin
        shadow[a + b] = word[b*8 +: 8];
      end
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_single();
    test_burst();
    test_strobe();
    test_interleave();
    test_backpressure();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sim/pmem_assertions.sv
// Protocol assertions bound to the memory slave top level
// Burst type and alignment, R stability, port exclusivity, OKAY responses

`timescale 1ns/100ps

module pmem_assertions
  import pmem_axi_pkg::*;
(
  input logic        clk_i,
  input logic        rst_i,
  input logic        aw_hs,
  input axi_addr_t   awaddr,
  input logic [1:0]  awburst,
  input logic        ar_hs,
  input axi_addr_t   araddr,
  input logic [1:0]  arburst,
  input logic        rvalid,
  input logic        rready,
  input axi_data_t   rdata,
  input axi_id_t     rid,
  input logic        rlast,
  input axi_resp_t   rresp,
  input logic        bvalid,
  input axi_resp_t   bresp,
  input logic        ram_rd,
  input logic [15:0] ram_wr
);

  aw_incr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    aw_hs |-> (awburst == BURST_INCR) && (awaddr[1:0] == 2'b00))
    else $error("AW burst is not an aligned INCR burst");

  ar_incr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    ar_hs |-> (arburst == BURST_INCR) && (araddr[1:0] == 2'b00))
    else $error("AR burst is not an aligned INCR burst");

  // R beat must hold until taken
  r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
    else $error("R beat changed before rready");

  port_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ram_rd && (ram_wr != '0)))
    else $error("Read and write presented together on the memory port");

  resp_okay: assert property (@(posedge clk_i) disable iff (rst_i)
    (!rvalid || rresp == RESP_OKAY) && (!bvalid || bresp == RESP_OKAY))
    else $error("Response code is not OKAY");

endmodule

bind ddr3_axi_pmem pmem_assertions u_assertions (
  .clk_i(clk_i), .rst_i(rst_i),
  .aw_hs(axi_awvalid_i && axi_awready_o), .awaddr(axi_awaddr_i), .awburst(axi_awburst_i),
  .ar_hs(axi_arvalid_i && axi_arready_o), .araddr(axi_araddr_i), .arburst(axi_arburst_i),
  .rvalid(axi_rvalid_o), .rready(axi_rready_i), .rdata(axi_rdata_o), .rid(axi_rid_o),
  .rlast(axi_rlast_o), .rresp(axi_rresp_o), .bvalid(axi_bvalid_o), .bresp(axi_bresp_o),
  .ram_rd(ram_rd_o), .ram_wr(ram_wr_o)
);

// File: source/ddr3_axi_pmem.sv
// AXI4 slave in front of a 128-bit pipelined memory port
// Request builder, request FIFO, response FIFO and unpacker

`timescale 1ns/100ps

module ddr3_axi_pmem
  import pmem_axi_pkg::*, pmem_ram_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       axi_awvalid_i,
  input  axi_addr_t  axi_awaddr_i,
  input  axi_id_t    axi_awid_i,
  input  axi_len_t   axi_awlen_i,
  // Burst type is not decoded, INCR is assumed
  input  logic [1:0] axi_awburst_i,
  input  logic       axi_wvalid_i,
  input  axi_data_t  axi_wdata_i,
  input  axi_strb_t  axi_wstrb_i,
  input  logic       axi_wlast_i,
  input  logic       axi_bready_i,
  input  logic       axi_arvalid_i,
  input  axi_addr_t  axi_araddr_i,
  input  axi_id_t    axi_arid_i,
  input  axi_len_t   axi_arlen_i,
  input  logic [1:0] axi_arburst_i,
  input  logic       axi_rready_i,
  input  logic       ram_accept_i,
  input  logic       ram_ack_i,
  input  req_tag_t   ram_resp_id_i,
  input  ram_data_t  ram_read_data_i,
  output logic       axi_awready_o,
  output logic       axi_wready_o,
  output logic       axi_bvalid_o,
  output axi_resp_t  axi_bresp_o,
  output axi_id_t    axi_bid_o,
  output logic       axi_arready_o,
  output logic       axi_rvalid_o,
  output axi_data_t  axi_rdata_o,
  output axi_resp_t  axi_rresp_o,
  output axi_id_t    axi_rid_o,
  output logic       axi_rlast_o,
  output ram_mask_t  ram_wr_o,
  output logic       ram_rd_o,
  output ram_addr_t  ram_addr_o,
  output ram_data_t  ram_write_data_o,
  output req_tag_t   ram_req_id_o
);

  localparam int REQ_W  = $bits(req_tag_t) + $bits(ram_data_t) + $bits(ram_addr_t) + 1
                          + $bits(ram_mask_t);
  localparam int RESP_W = $bits(req_tag_t) + $bits(ram_data_t);

  logic      req_push;
  logic      req_accept;
  ram_addr_t req_addr;
  ram_data_t req_wdata;
  ram_mask_t req_mask;
  logic      req_rd;
  req_tag_t  req_tag;
  logic      req_valid;
  logic      head_rd;
  ram_mask_t head_mask;
  logic      resp_push;
  logic      resp_valid;
  logic      resp_pop;
  req_tag_t  resp_tag;
  ram_data_t resp_data;
  logic      rd_done;
  logic      wr_done;

  //------------------------------------------------------------
  // Request side
  //------------------------------------------------------------
  pmem_req_builder u_builder (
    .clk_i(clk_i), .rst_i(rst_i),
    .awvalid_i(axi_awvalid_i), .awaddr_i(axi_awaddr_i),
    .awid_i(axi_awid_i), .awlen_i(axi_awlen_i),
    .wvalid_i(axi_wvalid_i), .wdata_i(axi_wdata_i),
    .wstrb_i(axi_wstrb_i), .wlast_i(axi_wlast_i),
    .arvalid_i(axi_arvalid_i), .araddr_i(axi_araddr_i),
    .arid_i(axi_arid_i), .arlen_i(axi_arlen_i),
    .rd_done_i(rd_done), .wr_done_i(wr_done), .req_accept_i(req_accept),
    .awready_o(axi_awready_o), .wready_o(axi_wready_o), .arready_o(axi_arready_o),
    .req_push_o(req_push), .req_addr_o(req_addr), .req_wdata_o(req_wdata),
    .req_mask_o(req_mask), .req_rd_o(req_rd), .req_tag_o(req_tag)
  );

  // FIFO head drives the memory port directly
  pmem_fifo #(.WIDTH(REQ_W), .DEPTH(REQ_FIFO_DEPTH)) u_request (
    .clk_i(clk_i), .rst_i(rst_i),
    .data_in_i({req_tag, req_wdata, req_addr, req_rd, req_mask}),
    .push_i(req_push), .accept_o(req_accept),
    .pop_i(ram_accept_i), .valid_o(req_valid),
    .data_out_o({ram_req_id_o, ram_write_data_o, ram_addr_o, head_rd, head_mask})
  );

  assign ram_rd_o = req_valid && head_rd;
  assign ram_wr_o = req_valid ? head_mask : '0;

  //------------------------------------------------------------
  // Response side
  //------------------------------------------------------------
  // Only read lines and the last line of a write are answered
  assign resp_push = ram_ack_i && (ram_resp_id_i[TAG_RD_BIT] || ram_resp_id_i[TAG_LAST_BIT]);

  pmem_fifo #(.WIDTH(RESP_W), .DEPTH(RESP_FIFO_DEPTH)) u_response (
    .clk_i(clk_i), .rst_i(rst_i),
    .data_in_i({ram_resp_id_i, ram_read_data_i}),
    .push_i(resp_push), .accept_o(),
    .pop_i(resp_pop), .valid_o(resp_valid),
    .data_out_o({resp_tag, resp_data})
  );

  pmem_resp_unpack u_unpack (
    .clk_i(clk_i), .rst_i(rst_i),
    .resp_valid_i(resp_valid), .resp_tag_i(resp_tag), .resp_data_i(resp_data),
    .rready_i(axi_rready_i), .bready_i(axi_bready_i), .resp_pop_o(resp_pop),
    .rvalid_o(axi_rvalid_o), .rdata_o(axi_rdata_o), .rid_o(axi_rid_o),
    .rlast_o(axi_rlast_o), .rresp_o(axi_rresp_o),
    .bvalid_o(axi_bvalid_o), .bid_o(axi_bid_o), .bresp_o(axi_bresp_o),
    .rd_done_o(rd_done), .wr_done_o(wr_done)
  );

endmodule

// File: source/pmem_resp_unpack.sv
// Response side of the pipelined memory slave
// Beat counter and lane select that turn queued memory
// responses into R beats and B responses

`timescale 1ns/100ps

module pmem_resp_unpack
  import pmem_axi_pkg::*, pmem_ram_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      resp_valid_i,
  input  req_tag_t  resp_tag_i,
  input  ram_data_t resp_data_i,
  input  logic      rready_i,
  input  logic      bready_i,
  output logic      resp_pop_o,
  output logic      rvalid_o,
  output axi_data_t rdata_o,
  output axi_id_t   rid_o,
  output logic      rlast_o,
  output axi_resp_t rresp_o,
  output logic      bvalid_o,
  output axi_id_t   bid_o,
  output axi_resp_t bresp_o,
  output logic      rd_done_o,
  output logic      wr_done_o
);

  localparam int BEAT_W = $bits(axi_data_t);

  axi_len_t  beat_q;
  lane_idx_t lane_q;
  axi_id_t   tag_id;
  axi_len_t  tag_len;
  lane_idx_t tag_off;
  logic      tag_rd;
  logic      tag_last;
  lane_idx_t lane;
  logic      final_beat;
  logic      r_hs;
  logic      b_hs;

  assign tag_id   = resp_tag_i[TAG_ID_LSB +: $bits(axi_id_t)];
  assign tag_len  = resp_tag_i[TAG_LEN_LSB +: $bits(axi_len_t)];
  assign tag_off  = resp_tag_i[TAG_OFF_LSB +: $bits(lane_idx_t)];
  assign tag_rd   = resp_tag_i[TAG_RD_BIT];
  assign tag_last = resp_tag_i[TAG_LAST_BIT];

  // First beat of a burst starts at the address lane
  assign lane       = (beat_q == '0) ? tag_off : lane_q;
  assign final_beat = (beat_q == tag_len);

  assign rvalid_o = resp_valid_i && tag_rd;
  assign rdata_o  = resp_data_i[lane*BEAT_W +: BEAT_W];
  assign rid_o    = tag_id;
  assign rlast_o  = tag_last && final_beat;
  assign rresp_o  = RESP_OKAY;

  assign bvalid_o = resp_valid_i && !tag_rd;
  assign bid_o    = tag_id;
  assign bresp_o  = RESP_OKAY;

  assign r_hs = rvalid_o && rready_i;
  assign b_hs = bvalid_o && bready_i;

  // Line is done after lane 3 or the final beat
  assign resp_pop_o = (r_hs && (final_beat || (lane == lane_idx_t'(LANES - 1)))) || b_hs;
  assign rd_done_o  = r_hs && rlast_o;
  assign wr_done_o  = b_hs;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_q <= '0;
    end else if (r_hs) begin
      beat_q <= final_beat ? '0 : beat_q + 8'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      lane_q <= lane + 2'd1;
    end
  end

endmodule

// File: source/pmem_req_builder.sv
// AXI request side of the pipelined memory slave
// Read/write round-robin arbitration, outstanding-burst limits,
// W beat gathering into lines and read burst line splitting

`timescale 1ns/100ps

module pmem_req_builder
  import pmem_axi_pkg::*, pmem_ram_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      awvalid_i,
  input  axi_addr_t awaddr_i,
  input  axi_id_t   awid_i,
  input  axi_len_t  awlen_i,
  input  logic      wvalid_i,
  input  axi_data_t wdata_i,
  input  axi_strb_t wstrb_i,
  input  logic      wlast_i,
  input  logic      arvalid_i,
  input  axi_addr_t araddr_i,
  input  axi_id_t   arid_i,
  input  axi_len_t  arlen_i,
  input  logic      rd_done_i,
  input  logic      wr_done_i,
  input  logic      req_accept_i,
  output logic      awready_o,
  output logic      wready_o,
  output logic      arready_o,
  output logic      req_push_o,
  output ram_addr_t req_addr_o,
  output ram_data_t req_wdata_o,
  output ram_mask_t req_mask_o,
  output logic      req_rd_o,
  output req_tag_t  req_tag_o
);

  localparam int BEAT_W = $bits(axi_data_t);
  localparam int STRB_W = $bits(axi_strb_t);

  typedef enum logic [1:0] {IDLE, READ_LINES, WRITE_GATHER} state_t;

  state_t               state_q;
  logic                 prio_rd_q;
  logic [PENDING_W-1:0] rd_pend_q;
  logic [PENDING_W-1:0] wr_pend_q;
  logic                 wfirst_q;
  axi_addr_t            awaddr_q;
  axi_id_t              awid_q;
  axi_len_t             awlen_q;
  logic                 rd_q;
  logic                 wr_q;
  logic                 last_q;
  axi_len_t             rd_remain_q;
  axi_addr_t            addr_q;
  axi_id_t              id_q;
  axi_len_t             len_q;
  lane_idx_t            widx_q;
  ram_data_t            line_q;
  ram_mask_t            mask_q;

  logic      aw_held;
  logic      awvalid_w;
  axi_addr_t awaddr_w;
  axi_id_t   awid_w;
  axi_len_t  awlen_w;
  logic      write_en;
  logic      read_en;
  logic      hold;
  logic      aw_hs;
  logic      take_ar;
  logic      take_w;
  logic      w_end;
  logic      next_line;
  lane_idx_t w_lane;
  ram_data_t line_d;
  ram_mask_t mask_d;

  //------------------------------------------------------------
  // Arbitration and handshakes
  //------------------------------------------------------------
  // Held AW command wins over the input until wlast
  assign aw_held   = (state_q == WRITE_GATHER);
  assign awvalid_w = awvalid_i || aw_held;
  assign awaddr_w  = aw_held ? awaddr_q : awaddr_i;
  assign awid_w    = aw_held ? awid_q : awid_i;
  assign awlen_w   = aw_held ? awlen_q : awlen_i;

  assign write_en = (!prio_rd_q || !arvalid_i) && (wr_pend_q < PENDING_W'(MAX_PENDING));
  assign read_en  = (prio_rd_q || !awvalid_w) && (rd_pend_q < PENDING_W'(MAX_PENDING));

  // Pending request stalled by a full request FIFO
  assign hold = (rd_q || wr_q) && !req_accept_i;

  assign awready_o = write_en && (state_q == IDLE);
  assign arready_o = read_en && !hold && (state_q == IDLE);
  assign wready_o  = write_en && awvalid_w && !hold && (state_q != READ_LINES);

  assign aw_hs     = awvalid_i && awready_o;
  assign take_ar   = arvalid_i && arready_o;
  assign take_w    = wvalid_i && wready_o;
  assign w_end     = take_w && wlast_i;
  assign next_line = (state_q == READ_LINES) && !hold;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (take_ar && (arlen_i[7:2] != '0)) begin
            state_q <= READ_LINES;
          end else if (aw_hs && !w_end) begin
            state_q <= WRITE_GATHER;
          end
        end
        READ_LINES: begin
          if (next_line && (rd_remain_q == 8'd1)) begin
            state_q <= IDLE;
          end
        end
        WRITE_GATHER: begin
          if (w_end) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_rd_q <= 1'b0;
      rd_pend_q <= '0;
      wr_pend_q <= '0;
      wfirst_q  <= 1'b1;
    end else begin
      // Write keeps priority through its burst, then it flips
      if (aw_hs && !w_end) begin
        prio_rd_q <= 1'b0;
      end else if (w_end || take_ar) begin
        prio_rd_q <= !prio_rd_q;
      end
      rd_pend_q <= rd_pend_q + PENDING_W'(take_ar) - PENDING_W'(rd_done_i);
      wr_pend_q <= wr_pend_q + PENDING_W'(w_end) - PENDING_W'(wr_done_i);
      if (take_w) begin
        wfirst_q <= wlast_i;
      end
    end
  end

  //------------------------------------------------------------
  // Write gathering
  //------------------------------------------------------------
  assign w_lane = wfirst_q ? awaddr_w[3:2] : widx_q;

  always_comb begin
    line_d = line_q;
    mask_d = mask_q;
    // New line starts with no bytes enabled
    if (wfirst_q || (w_lane == '0)) begin
      mask_d = '0;
    end
    for (int l = 0; l < LANES; l++) begin
      if (w_lane == lane_idx_t'(l)) begin
        line_d[l*BEAT_W +: BEAT_W] = wdata_i;
        mask_d[l*STRB_W +: STRB_W] = wstrb_i;
      end
    end
  end

  //------------------------------------------------------------
  // Request register
  //------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      last_q      <= 1'b0;
      rd_remain_q <= '0;
    end else if (!hold) begin
      if (take_ar) begin
        rd_q        <= 1'b1;
        wr_q        <= 1'b0;
        last_q      <= (arlen_i[7:2] == '0);
        rd_remain_q <= {2'b00, arlen_i[7:2]};
      end else if (next_line) begin
        rd_q        <= 1'b1;
        last_q      <= (rd_remain_q == 8'd1);
        rd_remain_q <= rd_remain_q - 8'd1;
      end else if (take_w) begin
        // Line goes out once lane 3 is filled or the burst ends
        rd_q   <= 1'b0;
        wr_q   <= wlast_i || (w_lane == lane_idx_t'(LANES - 1));
        last_q <= wlast_i;
      end else begin
        rd_q   <= 1'b0;
        wr_q   <= 1'b0;
        last_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awaddr_q <= awaddr_i;
      awid_q   <= awid_i;
      awlen_q  <= awlen_i;
    end
    if (take_ar) begin
      addr_q <= araddr_i;
      id_q   <= arid_i;
      len_q  <= arlen_i;
    end else if (next_line) begin
      addr_q <= addr_q + axi_addr_t'(LINE_BYTES);
    end else if (take_w) begin
      addr_q <= wfirst_q ? awaddr_w : addr_q + axi_addr_t'(STRB_W);
      line_q <= line_d;
      mask_q <= mask_d;
      widx_q <= w_lane + 2'd1;
      id_q   <= awid_w;
      len_q  <= awlen_w;
    end
  end

  // All-zero write lines are not sent to the memory
  assign req_push_o  = rd_q || (wr_q && (|mask_q));
  assign req_rd_o    = rd_q;
  assign req_addr_o  = {addr_q[31:4], 4'b0000};
  assign req_wdata_o = line_q;
  assign req_mask_o  = wr_q ? mask_q : '0;
  assign req_tag_o   = {id_q, len_q, addr_q[3:2], rd_q, last_q};

endmodule

// File: source/pmem_fifo.sv
// Synchronous FIFO with push/accept on the input side
// and pop/valid on the output side

`timescale 1ns/100ps

module pmem_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] data_in_i,
  input  logic             push_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_out_o,
  output logic             accept_o,
  output logic             valid_o
);

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]   mem_q [DEPTH];
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [COUNT_W-1:0] count_q;
  logic               do_push;
  logic               do_pop;

  // Wrap at DEPTH, so non power-of-two depths work too
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push_i && accept_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_in_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Simultaneous push and pop keep the count
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign accept_o   = (count_q != COUNT_W'(DEPTH));
  assign valid_o    = (count_q != '0);
  assign data_out_o = mem_q[rd_ptr_q];

endmodule

// File: source/pmem_ram_pkg.sv
// Memory-port definitions for the pipelined memory slave
// Line, mask and tag types, tag field positions
// Lane geometry and FIFO depths

package pmem_ram_pkg;

  //------------------------------------------------------------
  // Memory port
  //------------------------------------------------------------
  // Line address, low 4 bits always zero
  typedef logic [31:0]  ram_addr_t;
  typedef logic [127:0] ram_data_t;
  typedef logic [15:0]  ram_mask_t;

  // Tag, MSB first: id(4) len(8) offset(2) rd(1) last(1)
  typedef logic [15:0]  req_tag_t;
  localparam int TAG_ID_LSB   = 12;
  localparam int TAG_LEN_LSB  = 4;
  localparam int TAG_OFF_LSB  = 2;
  localparam int TAG_RD_BIT   = 1;
  localparam int TAG_LAST_BIT = 0;

  //------------------------------------------------------------
  // Lane geometry and buffering
  //------------------------------------------------------------
  typedef logic [1:0] lane_idx_t;
  localparam int LANES           = 4;
  localparam int LINE_BYTES      = 16;
  localparam int REQ_FIFO_DEPTH  = 2;
  localparam int RESP_FIFO_DEPTH = 8;

endpackage

// File: source/pmem_axi_pkg.sv
// AXI-side definitions for the pipelined memory slave
// Channel field widths, burst and response codes
// Limit on outstanding bursts per direction

package pmem_axi_pkg;

  //------------------------------------------------------------
  // Channel fields
  //------------------------------------------------------------
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;

  //------------------------------------------------------------
  // Encodings
  //------------------------------------------------------------
  // Only incrementing bursts are handled
  localparam logic [1:0] BURST_INCR = 2'd1;
  localparam axi_resp_t  RESP_OKAY  = 2'd0;

  //------------------------------------------------------------
  // Outstanding bursts
  //------------------------------------------------------------
  localparam int MAX_PENDING = 6;
  // Wide enough for MAX_PENDING plus headroom
  localparam int PENDING_W   = 4;

endpackage
